// ==== flist.f ====
logic/cpu_pkg.sv
logic/cpu_control.sv
logic/instr_decoder.sv
logic/operand_latch.sv
logic/alu.sv
logic/register_file.sv
logic/cpu_top.sv
verif/cpu_tb.sv

// ==== logic/alu.sv ====
module alu import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  stage_e   stage,
  input  decoded_t decoded,
  input  data_t    reg_a,
  input  data_t    reg_sp,
  input  data_t    imm,
  input  data_t    mem_src,
  input  data_t    mem_dst,
  output data_t    result
);

  data_t src_value;
  data_t dst_value;

  always_comb begin
    case (decoded.src)
      REG_A:                                     src_value = reg_a;
      REG_SP:                                    src_value = reg_sp;
      IMM:                                       src_value = imm;
      ADDRESS_IMM, ADDRESS_REG_A, ADDRESS_REG_SP: src_value = mem_src;
      default:                                   src_value = 8'd0;
    endcase
  end

  // Value held by the destination before this instruction
  always_comb begin
    case (decoded.dst)
      REG_A:                                     dst_value = reg_a;
      REG_SP:                                    dst_value = reg_sp;
      ADDRESS_IMM, ADDRESS_REG_A, ADDRESS_REG_SP: dst_value = mem_dst;
      default:                                   dst_value = 8'd0;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      result <= 8'd0;
    end else if (stage == EXECUTE) begin
      case (decoded.op)
        ADD:           result <= dst_value + src_value;
        MOV, PUSH, POP: result <= src_value;
        default:       result <= dst_value;
      endcase
    end
  end

endmodule

// ==== logic/cpu_control.sv ====
module cpu_control import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  decoded_t decoded,
  input  data_t    imm,
  input  data_t    operand_addr,
  input  data_t    result,
  output stage_e   stage,
  output capture_e capture,
  output mem_req_t mem_req,
  output logic     halted
);

  stage_e next_stage;
  stage_e dst_step;
  data_t  ip;
  logic   need_imm;
  logic   need_src_addr;
  logic   need_src;
  logic   need_dst_addr;
  logic   need_dst;

  assign need_imm      = (decoded.src == IMM);
  assign need_src_addr = (decoded.src == ADDRESS_IMM);
  assign need_src      = decoded.src inside {ADDRESS_IMM, ADDRESS_REG_A, ADDRESS_REG_SP};
  assign need_dst_addr = (decoded.dst == ADDRESS_IMM);
  assign need_dst      = decoded.dst inside {ADDRESS_IMM, ADDRESS_REG_A, ADDRESS_REG_SP};

  // First destination step, or straight to execute
  always_comb begin
    if (need_dst_addr) begin
      dst_step = DST_ADDR_REQ;
    end else if (need_dst) begin
      dst_step = DST_REQ;
    end else begin
      dst_step = EXECUTE;
    end
  end

  always_comb begin
    case (stage)
      FETCH_REQ:        next_stage = FETCH_CAPTURE;
      FETCH_CAPTURE:    next_stage = DECODE;
      DECODE: begin
        if (decoded.op == HLT) begin
          next_stage = HALTED;
        end else if (need_imm) begin
          next_stage = IMM_REQ;
        end else if (need_src_addr) begin
          next_stage = SRC_ADDR_REQ;
        end else if (need_src) begin
          next_stage = SRC_REQ;
        end else begin
          next_stage = dst_step;
        end
      end
      IMM_REQ:          next_stage = IMM_CAPTURE;
      IMM_CAPTURE:      next_stage = dst_step;
      SRC_ADDR_REQ:     next_stage = SRC_ADDR_CAPTURE;
      SRC_ADDR_CAPTURE: next_stage = SRC_REQ;
      SRC_REQ:          next_stage = SRC_CAPTURE;
      SRC_CAPTURE:      next_stage = dst_step;
      DST_ADDR_REQ:     next_stage = DST_ADDR_CAPTURE;
      DST_ADDR_CAPTURE: next_stage = DST_REQ;
      DST_REQ:          next_stage = DST_CAPTURE;
      DST_CAPTURE:      next_stage = EXECUTE;
      EXECUTE:          next_stage = WRITE_REGISTER;
      WRITE_REGISTER:   next_stage = need_dst ? WRITE_MEMORY : FETCH_REQ;
      WRITE_MEMORY:     next_stage = FETCH_REQ;
      default:          next_stage = HALTED;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= FETCH_REQ;
      ip    <= 8'd0;
    end else begin
      stage <= next_stage;
      case (stage)
        FETCH_CAPTURE, IMM_CAPTURE, SRC_ADDR_CAPTURE, DST_ADDR_CAPTURE: begin
          ip <= ip + 8'd1;
        end
        // ip already points past the offset byte here
        EXECUTE: begin
          if (decoded.op == JMP) begin
            ip <= ip + imm;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Names the operand register that this cycle's read will load
  always_comb begin
    case (stage)
      IMM_REQ:      capture = CAP_IMM;
      SRC_ADDR_REQ: capture = CAP_SRC_ADDR;
      SRC_REQ:      capture = CAP_SRC;
      DST_ADDR_REQ: capture = CAP_DST_ADDR;
      DST_REQ:      capture = CAP_DST;
      default:      capture = CAP_NONE;
    endcase
  end

  always_comb begin
    mem_req.wdata = result;
    case (stage)
      FETCH_REQ, IMM_REQ, SRC_ADDR_REQ, DST_ADDR_REQ: begin
        mem_req.cmd  = MEM_READ;
        mem_req.addr = ip;
      end
      SRC_REQ, DST_REQ: begin
        mem_req.cmd  = MEM_READ;
        mem_req.addr = operand_addr;
      end
      WRITE_MEMORY: begin
        mem_req.cmd  = MEM_WRITE;
        mem_req.addr = operand_addr;
      end
      default: begin
        mem_req.cmd  = MEM_STAY;
        mem_req.addr = operand_addr;
      end
    endcase
  end

  assign halted = (stage == HALTED);

  a_write_only_to_mem_dst: assert property (
    @(posedge CLOCK) disable iff (RESET)
    (mem_req.cmd == MEM_WRITE) |-> (stage == WRITE_MEMORY) && need_dst
  );

  a_halted_sticky: assert property (
    @(posedge CLOCK) disable iff (RESET)
    halted |=> halted
  );

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

  // Data, address and instruction pointer share one byte width
  typedef logic [7:0] data_t;

  typedef enum logic [2:0] {
    MOV,
    ADD,
    PUSH,
    POP,
    JMP,
    NOP,
    HLT
  } opcode_e;

  typedef enum logic [2:0] {
    UNUSED,
    REG_A,
    REG_SP,
    IMM,
    ADDRESS_IMM,
    ADDRESS_REG_A,
    ADDRESS_REG_SP
  } operand_e;

  // Each REQ state issues one read, its CAPTURE state sees the data
  typedef enum logic [4:0] {
    FETCH_REQ, FETCH_CAPTURE,
    DECODE,
    IMM_REQ, IMM_CAPTURE,
    SRC_ADDR_REQ, SRC_ADDR_CAPTURE,
    SRC_REQ, SRC_CAPTURE,
    DST_ADDR_REQ, DST_ADDR_CAPTURE,
    DST_REQ, DST_CAPTURE,
    EXECUTE, WRITE_REGISTER, WRITE_MEMORY, HALTED
  } stage_e;

  typedef enum logic [1:0] {
    MEM_STAY,
    MEM_READ,
    MEM_WRITE
  } mem_cmd_e;

  typedef struct packed {
    mem_cmd_e cmd;
    data_t    addr;
    data_t    wdata;
  } mem_req_t;

  typedef struct packed {
    opcode_e  op;
    operand_e src;
    operand_e dst;
  } decoded_t;

  typedef enum logic [2:0] {
    CAP_NONE, CAP_IMM, CAP_SRC_ADDR, CAP_SRC, CAP_DST_ADDR, CAP_DST
  } capture_e;

  // Opcode byte layout: class, destination field, source field
  localparam int OPCODE_CLASS_MSB = 7;
  localparam int OPCODE_CLASS_LSB = 6;
  localparam int DST_FIELD_MSB    = 5;
  localparam int DST_FIELD_LSB    = 3;
  localparam int SRC_FIELD_MSB    = 2;
  localparam int SRC_FIELD_LSB    = 0;

  localparam data_t NOP_BYTE = 8'b11_111_110;
  localparam data_t HLT_BYTE = 8'b11_111_111;

endpackage

// ==== logic/cpu_top.sv ====
module cpu_top import cpu_pkg::*; #(
  parameter data_t SP_RESET = 8'd240
) (
  input  logic     CLOCK,
  input  logic     RESET,
  input  data_t    read_bus,
  output mem_req_t mem_req,
  output data_t    reg_a_out,
  output logic     halted
);

  stage_e   stage;
  capture_e capture;
  decoded_t decoded;
  data_t    imm;
  data_t    mem_src;
  data_t    mem_dst;
  data_t    operand_addr;
  data_t    result;
  data_t    reg_a;
  data_t    reg_sp;

  cpu_control u_control (
    .CLOCK(CLOCK), .RESET(RESET),
    .decoded(decoded), .imm(imm), .operand_addr(operand_addr), .result(result),
    .stage(stage), .capture(capture), .mem_req(mem_req), .halted(halted)
  );

  instr_decoder u_decoder (
    .CLOCK(CLOCK), .RESET(RESET),
    .stage(stage), .read_bus(read_bus), .decoded(decoded)
  );

  operand_latch u_operands (
    .CLOCK(CLOCK), .RESET(RESET),
    .capture(capture), .read_bus(read_bus), .decoded(decoded),
    .reg_a(reg_a), .reg_sp(reg_sp),
    .imm(imm), .mem_src(mem_src), .mem_dst(mem_dst), .operand_addr(operand_addr)
  );

  alu u_alu (
    .CLOCK(CLOCK), .RESET(RESET),
    .stage(stage), .decoded(decoded),
    .reg_a(reg_a), .reg_sp(reg_sp), .imm(imm), .mem_src(mem_src), .mem_dst(mem_dst),
    .result(result)
  );

  register_file #(.SP_RESET(SP_RESET)) u_regs (
    .CLOCK(CLOCK), .RESET(RESET),
    .stage(stage), .decoded(decoded), .result(result),
    .reg_a(reg_a), .reg_sp(reg_sp)
  );

  assign reg_a_out = reg_a;

endmodule

// ==== logic/instr_decoder.sv ====
module instr_decoder import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  stage_e   stage,
  input  data_t    read_bus,
  output decoded_t decoded
);

  data_t      opcode_byte;
  decoded_t   next_decoded;
  decoded_t   decoded_q;
  logic [1:0] op_class;
  logic [2:0] dst_field;
  logic [2:0] src_field;

  function automatic operand_e field_kind(input logic [2:0] field);
    case (field)
      3'b000:         return REG_A;
      3'b001:         return ADDRESS_REG_A;
      3'b010, 3'b110: return ADDRESS_IMM;
      3'b100:         return REG_SP;
      3'b101:         return ADDRESS_REG_SP;
      default:        return IMM;
    endcase
  endfunction

  always_ff @(posedge CLOCK) begin
    if (stage == FETCH_CAPTURE) begin
      opcode_byte <= read_bus;
    end
  end

  assign op_class  = opcode_byte[OPCODE_CLASS_MSB:OPCODE_CLASS_LSB];
  assign dst_field = opcode_byte[DST_FIELD_MSB:DST_FIELD_LSB];
  assign src_field = opcode_byte[SRC_FIELD_MSB:SRC_FIELD_LSB];

  always_comb begin
    // Unknown encodings stop the machine
    next_decoded = '{op: HLT, src: UNUSED, dst: UNUSED};
    case (op_class)
      2'b00: next_decoded = '{op: MOV, src: field_kind(src_field), dst: field_kind(dst_field)};
      2'b01: next_decoded = '{op: ADD, src: field_kind(src_field), dst: field_kind(dst_field)};
      2'b11: begin
        if (opcode_byte == NOP_BYTE) begin
          next_decoded = '{op: NOP, src: UNUSED, dst: UNUSED};
        end else if (dst_field == 3'b000) begin
          next_decoded = '{op: PUSH, src: field_kind(src_field), dst: ADDRESS_REG_SP};
        end else if (dst_field == 3'b001) begin
          next_decoded = '{op: POP, src: ADDRESS_REG_SP, dst: field_kind(src_field)};
        end else if (dst_field == 3'b010 && src_field == 3'b000) begin
          next_decoded = '{op: JMP, src: IMM, dst: UNUSED};
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      decoded_q <= '{op: NOP, src: UNUSED, dst: UNUSED};
    end else if (stage == DECODE) begin
      decoded_q <= next_decoded;
    end
  end

  // Control picks its first operand step while still in DECODE
  assign decoded = (stage == DECODE) ? next_decoded : decoded_q;

endmodule

// ==== logic/operand_latch.sv ====
module operand_latch import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  capture_e capture,
  input  data_t    read_bus,
  input  decoded_t decoded,
  input  data_t    reg_a,
  input  data_t    reg_sp,
  output data_t    imm,
  output data_t    mem_src,
  output data_t    mem_dst,
  output data_t    operand_addr
);

  capture_e capture_q;
  data_t    src_addr;
  data_t    dst_addr;
  data_t    src_operand_addr;
  data_t    dst_operand_addr;

  // Read data arrives one cycle after the request
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      capture_q <= CAP_NONE;
    end else begin
      capture_q <= capture;
    end
  end

  always_ff @(posedge CLOCK) begin
    case (capture_q)
      CAP_IMM:      imm      <= read_bus;
      CAP_SRC_ADDR: src_addr <= read_bus;
      CAP_SRC:      mem_src  <= read_bus;
      CAP_DST_ADDR: dst_addr <= read_bus;
      CAP_DST:      mem_dst  <= read_bus;
      default: begin
      end
    endcase
  end

  always_comb begin
    case (decoded.src)
      ADDRESS_REG_A:  src_operand_addr = reg_a;
      ADDRESS_REG_SP: src_operand_addr = reg_sp;
      default:        src_operand_addr = src_addr;
    endcase
  end

  // Register based addresses track the live registers, so a push writes below the old sp
  always_comb begin
    case (decoded.dst)
      ADDRESS_REG_A:  dst_operand_addr = reg_a;
      ADDRESS_REG_SP: dst_operand_addr = reg_sp;
      default:        dst_operand_addr = dst_addr;
    endcase
  end

  assign operand_addr = (capture == CAP_SRC) ? src_operand_addr : dst_operand_addr;

  a_src_read_needs_mem_src: assert property (
    @(posedge CLOCK) disable iff (RESET)
    (capture == CAP_SRC) |-> decoded.src inside {ADDRESS_IMM, ADDRESS_REG_A, ADDRESS_REG_SP}
  );

endmodule

// ==== logic/register_file.sv ====
module register_file import cpu_pkg::*; #(
  parameter data_t SP_RESET = 8'd240
) (
  input  logic     CLOCK,
  input  logic     RESET,
  input  stage_e   stage,
  input  decoded_t decoded,
  input  data_t    result,
  output data_t    reg_a,
  output data_t    reg_sp
);

  logic write_en;

  assign write_en = (stage == WRITE_REGISTER);

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      reg_a <= 8'd0;
    end else if (write_en && decoded.dst == REG_A) begin
      reg_a <= result;
    end
  end

  // A POP into sp takes the popped value without the increment
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      reg_sp <= SP_RESET;
    end else if (write_en) begin
      if (decoded.dst == REG_SP) begin
        reg_sp <= result;
      end else if (decoded.op == PUSH) begin
        reg_sp <= reg_sp - 8'd1;
      end else if (decoded.op == POP) begin
        reg_sp <= reg_sp + 8'd1;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CPU testbench with Verilator, runs it and searches the log for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module cpu_tb -f flist.f -o cpu_sim || exit 1
./obj_dir/cpu_sim | tee sim.log
grep -q "^ALL TESTS PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== verif/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam data_t SP_RESET     = 8'd240;
  localparam int    NUM_PROGRAMS = 20;
  localparam int    MAX_INSTR    = 40;
  localparam int    WATCHDOG_NS  = (NUM_PROGRAMS + 2) * (MAX_INSTR * 16 + 40) * 10;

  // Operand kinds and operations as the reference model sees them
  typedef enum {K_NONE, K_A, K_SP, K_IMM, K_AIMM, K_AA, K_ASP} kind_e;
  typedef enum {OP_MOV, OP_ADD, OP_PUSH, OP_POP, OP_JMP, OP_NOP, OP_HLT} op_e;

  logic     CLOCK = 1'b0;
  logic     RESET = 1'b1;
  data_t    read_bus = 8'd0;
  mem_req_t mem_req;
  data_t    reg_a_out;
  logic     halted;

  data_t image [256];
  data_t mem [256];
  data_t exp_wr_addr [$];
  data_t exp_wr_data [$];
  data_t obs_wr_addr [$];
  data_t instr_ip [$];
  int    instr_reads [$];
  data_t model_a;
  int    seed;
  int    errors = 0;
  int    checks = 0;

  cpu_top #(.SP_RESET(SP_RESET)) dut_i (
    .CLOCK(CLOCK), .RESET(RESET), .read_bus(read_bus),
    .mem_req(mem_req), .reg_a_out(reg_a_out), .halted(halted)
  );

  always #5 CLOCK = ~CLOCK;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  function automatic int rand_below(input int range);
    return int'($unsigned($random(seed)) % range);
  endfunction

  function automatic kind_e field_kind(input logic [2:0] field);
    case (field)
      3'b000:         return K_A;
      3'b001:         return K_AA;
      3'b010, 3'b110: return K_AIMM;
      3'b100:         return K_SP;
      3'b101:         return K_ASP;
      default:        return K_IMM;
    endcase
  endfunction

  function automatic bit is_mem(input kind_e k);
    return k == K_AIMM || k == K_AA || k == K_ASP;
  endfunction

  // Instruction level model over a copy of the image
  task automatic run_model(output bit ok);
    data_t m [256];
    data_t ip;
    data_t a;
    data_t sp;
    data_t op_byte;
    data_t src_byte;
    data_t dst_addr;
    data_t sv;
    data_t dv;
    data_t res;
    kind_e src_k;
    kind_e dst_k;
    op_e   op;
    int    reads;
    m = image;
    ip = 8'd0;
    a = 8'd0;
    sp = SP_RESET;
    src_byte = 8'd0;
    ok = 1'b0;
    exp_wr_addr.delete();
    exp_wr_data.delete();
    instr_ip.delete();
    instr_reads.delete();
    while (!ok && instr_ip.size() < MAX_INSTR) begin
      instr_ip.push_back(ip);
      op_byte = m[ip];
      ip++;
      reads = 1;
      src_k = K_NONE;
      dst_k = K_NONE;
      op = OP_HLT;
      if (!op_byte[7]) begin
        op = op_byte[6] ? OP_ADD : OP_MOV;
        src_k = field_kind(op_byte[2:0]);
        dst_k = field_kind(op_byte[5:3]);
      end else if (op_byte == 8'hfe) begin
        op = OP_NOP;
      end else if (op_byte[7:3] == 5'b11_000) begin
        op = OP_PUSH;
        src_k = field_kind(op_byte[2:0]);
        dst_k = K_ASP;
      end else if (op_byte[7:3] == 5'b11_001) begin
        op = OP_POP;
        src_k = K_ASP;
        dst_k = field_kind(op_byte[2:0]);
      end else if (op_byte == 8'hd0) begin
        op = OP_JMP;
        src_k = K_IMM;
      end
      if (op == OP_HLT) begin
        ok = 1'b1;
      end else begin
        if (src_k == K_IMM || src_k == K_AIMM) begin
          src_byte = m[ip];
          ip++;
          reads++;
        end
        case (src_k)
          K_A:     sv = a;
          K_SP:    sv = sp;
          K_IMM:   sv = src_byte;
          K_AIMM:  sv = m[src_byte];
          K_AA:    sv = m[a];
          K_ASP:   sv = m[sp];
          default: sv = 8'd0;
        endcase
        if (is_mem(src_k)) begin
          reads++;
        end
        dst_addr = (dst_k == K_AA) ? a : sp;
        if (dst_k == K_AIMM) begin
          dst_addr = m[ip];
          ip++;
          reads++;
        end
        case (dst_k)
          K_A:                  dv = a;
          K_SP:                 dv = sp;
          K_AIMM, K_AA, K_ASP:  dv = m[dst_addr];
          default:              dv = 8'd0;
        endcase
        if (is_mem(dst_k)) begin
          reads++;
        end
        res = (op == OP_ADD) ? dv + sv : (op == OP_JMP || op == OP_NOP) ? dv : sv;
        if (op == OP_JMP) begin
          ip = ip + src_byte;
        end
        if (dst_k == K_A) begin
          a = res;
        end
        // Popping into sp keeps the popped value
        if (dst_k == K_SP) begin
          sp = res;
        end else if (op == OP_PUSH) begin
          sp--;
        end else if (op == OP_POP) begin
          sp++;
        end
        if (is_mem(dst_k)) begin
          if (dst_k == K_ASP) begin
            dst_addr = sp;
          end
          m[dst_addr] = res;
          exp_wr_addr.push_back(dst_addr);
          exp_wr_data.push_back(res);
        end
      end
      instr_reads.push_back(reads);
    end
    model_a = a;
  endtask

  task automatic load_directed(input logic [127:0] code, input int len);
    for (int i = 0; i < 256; i++) begin
      image[8'(i)] = 8'(i * 7 + 3);
    end
    for (int i = len - 1; i >= 0; i--) begin
      image[8'(i)] = code[7:0];
      code = code >> 8;
    end
  endtask

  // Code below 128, operand addresses point into the data area above it
  task automatic build_random_program();
    int         pos;
    int         count;
    int         kind;
    int         skip;
    logic [2:0] src_f;
    logic [2:0] dst_f;
    for (int i = 0; i < 256; i++) begin
      image[8'(i)] = 8'(rand_below(256));
    end
    pos = 0;
    count = 12 + rand_below(19);
    for (int i = 0; i < count && pos <= 122; i++) begin
      kind = rand_below(6);
      src_f = 3'(rand_below(8));
      dst_f = 3'(rand_below(8));
      case (kind)
        0:       image[8'(pos)] = {2'b00, dst_f, src_f};
        1:       image[8'(pos)] = {2'b01, dst_f, src_f};
        2:       image[8'(pos)] = {5'b11_000, src_f};
        3:       image[8'(pos)] = {5'b11_001, src_f};
        4:       image[8'(pos)] = 8'hd0;
        default: image[8'(pos)] = 8'hfe;
      endcase
      pos++;
      // Immediate bytes keep their random fill
      if (kind <= 2 && src_f[1]) begin
        if (!src_f[0]) begin
          image[8'(pos)] = {1'b1, 7'(rand_below(128))};
        end
        pos++;
      end
      if ((kind <= 1 && dst_f[1:0] == 2'b10) || (kind == 3 && src_f[1:0] == 2'b10)) begin
        image[8'(pos)] = {1'b1, 7'(rand_below(128))};
        pos++;
      end
      if (kind == 4) begin
        skip = rand_below(4);
        image[8'(pos)] = 8'(skip);
        pos = pos + 1 + skip;
      end
    end
    image[8'(pos)] = 8'hff;
  endtask

  task automatic run_program(input string name);
    int    cycles;
    int    wr_idx;
    int    instr_idx;
    int    reads_left;
    bit    pending;
    data_t pend_addr;
    mem = image;
    obs_wr_addr.delete();
    wr_idx = 0;
    instr_idx = 0;
    reads_left = 0;
    pending = 1'b0;
    pend_addr = 8'd0;
    cycles = 0;
    RESET = 1'b1;
    repeat (8) @(negedge CLOCK);
    RESET = 1'b0;
    check({name, " reset reg_a"}, 0, int'(reg_a_out));
    check({name, " reset halted"}, 0, int'(halted));
    check({name, " first request"}, int'(MEM_READ), int'(mem_req.cmd));
    check({name, " first address"}, 0, int'(mem_req.addr));
    while (!halted && cycles < MAX_INSTR * 16) begin
      // Read data from the previous cycle's request
      if (pending) begin
        read_bus = mem[pend_addr];
      end
      pending = 1'b0;
      if (mem_req.cmd == MEM_READ) begin
        if (reads_left == 0 && instr_idx < instr_ip.size()) begin
          check({name, " fetch address"}, int'(instr_ip[instr_idx]), int'(mem_req.addr));
          reads_left = instr_reads[instr_idx];
          instr_idx++;
        end else if (reads_left == 0) begin
          errors++;
          $display("%s: opcode fetch at 0x%0h after the reference run ended", name,
                   mem_req.addr);
          reads_left = 1;
        end
        reads_left--;
        pending = 1'b1;
        pend_addr = mem_req.addr;
      end else if (mem_req.cmd == MEM_WRITE) begin
        if (wr_idx < exp_wr_addr.size()) begin
          check({name, " write address"}, int'(exp_wr_addr[wr_idx]), int'(mem_req.addr));
          check({name, " write data"}, int'(exp_wr_data[wr_idx]), int'(mem_req.wdata));
        end else begin
          errors++;
          $display("%s: unexpected memory write at 0x%0h", name, mem_req.addr);
        end
        mem[mem_req.addr] = mem_req.wdata;
        obs_wr_addr.push_back(mem_req.addr);
        wr_idx++;
      end
      @(negedge CLOCK);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("%s: CPU did not halt within %0d cycles", name, cycles);
    end
    check({name, " final reg_a"}, int'(model_a), int'(reg_a_out));
    check({name, " instruction count"}, instr_ip.size(), instr_idx);
    check({name, " write count"}, exp_wr_addr.size(), wr_idx);
    repeat (20) begin
      @(negedge CLOCK);
      check({name, " bus idle after halt"}, int'(MEM_STAY), int'(mem_req.cmd));
      check({name, " halted held"}, 1, int'(halted));
    end
  endtask

  initial begin
    bit ok;
    seed = 24;
    // Three pushes, clear A, three pops
    load_directed(128'h035ac0_033cc0_0396c0_0300_c8c8c8_ff, 15);
    run_model(ok);
    run_program("push_pop");
    check("push_pop write count", 3, obs_wr_addr.size());
    for (int i = 0; i < obs_wr_addr.size() && i < 3; i++) begin
      check($sformatf("push_pop write %0d address", i), int'(SP_RESET) - 1 - i,
            int'(obs_wr_addr[i]));
    end
    check("push_pop restored reg_a", 'h5a, int'(reg_a_out));
    // Class 10 opcode right after a move
    load_directed(128'h030780, 3);
    run_model(ok);
    run_program("illegal_opcode");
    check("illegal_opcode reg_a", 7, int'(reg_a_out));
    for (int p = 0; p < NUM_PROGRAMS; p++) begin
      do begin
        build_random_program();
        run_model(ok);
      end while (!ok);
      run_program($sformatf("random_%0d", p));
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
